// ==== testbench/xbar_tests.txt ====
# Columns (hex): initiator op(0 read, 1 write) addr wdata strb exp_rdata exp_resp
# Writes return zero data; resp 0 is OKAY, 3 is DECERR
0 1 0010 11223344 f 00000000 0
1 1 0014 55667788 f 00000000 0
0 0 0010 00000000 0 11223344 0
1 0 0014 00000000 0 55667788 0
0 1 0010 aabbccdd 3 00000000 0
1 1 1024 0badc0de 9 00000000 0
0 0 0010 00000000 0 1122ccdd 0
1 0 1024 00000000 0 0b0000de 0
0 1 1020 deadbeef f 00000000 0
1 0 8000 00000000 0 00000000 3
0 0 1020 00000000 0 deadbeef 0
1 1 1ffc a5a5a5a5 f 00000000 0
0 0 2000 00000000 0 00000000 3
1 0 1ffc 00000000 0 a5a5a5a5 0
0 1 f004 12345678 f 00000000 3
1 1 0200 cafef00d c 00000000 0
0 1 0100 13579bdf 6 00000000 0
1 0 0200 00000000 0 cafe0000 0
0 0 0100 00000000 0 00579b00 0

// ==== filelist.f ====
src/xbar_pkg.sv
src/xbar_addr_decode.sv
src/xbar_demux.sv
src/xbar_err_target.sv
src/xbar_mux.sv
src/xbar_top.sv
testbench/tb_xbar.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the crossbar testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --top-module tb_xbar -f filelist.f -o sim_xbar > build.log 2>&1 \
  && ./obj_dir/sim_xbar > sim.log 2>&1
grep -qxF '** PASS **' sim.log && echo "Simulation passed" && exit 0 \
  || { echo "Simulation failed, see sim.log and build.log"; exit 1; }

// ==== testbench/tb_xbar.sv ====
`default_nettype none

module tb_xbar;

  localparam int TIMEOUT   = 1000;  // Cycles allowed per handshake wait
  localparam int MAX_TESTS = 64;

  logic clk_i;
  logic rst_i;
  logic go = 1'b0;                  // Released after the reset checks
  logic [xbar_pkg::NUM_INIT-1:0] init_done;

  logic [xbar_pkg::NUM_INIT-1:0]                        init_req_valid_i;
  logic [xbar_pkg::NUM_INIT-1:0]                        init_req_ready_o;
  logic [xbar_pkg::NUM_INIT-1:0][xbar_pkg::ADDR_W-1:0]  init_req_addr_i;
  xbar_pkg::xbar_op_e [xbar_pkg::NUM_INIT-1:0]          init_req_op_i;
  logic [xbar_pkg::NUM_INIT-1:0][xbar_pkg::DATA_W-1:0]  init_req_wdata_i;
  logic [xbar_pkg::NUM_INIT-1:0][xbar_pkg::STRB_W-1:0]  init_req_strb_i;
  logic [xbar_pkg::NUM_INIT-1:0]                        init_rsp_valid_o;
  logic [xbar_pkg::NUM_INIT-1:0]                        init_rsp_ready_i;
  logic [xbar_pkg::NUM_INIT-1:0][xbar_pkg::DATA_W-1:0]  init_rsp_rdata_o;
  xbar_pkg::xbar_resp_e [xbar_pkg::NUM_INIT-1:0]        init_rsp_resp_o;
  logic [xbar_pkg::NUM_TGT-1:0]                         tgt_req_valid_o;
  logic [xbar_pkg::NUM_TGT-1:0]                         tgt_req_ready_i;
  logic [xbar_pkg::NUM_TGT-1:0][xbar_pkg::ADDR_W-1:0]   tgt_req_addr_o;
  xbar_pkg::xbar_op_e [xbar_pkg::NUM_TGT-1:0]           tgt_req_op_o;
  logic [xbar_pkg::NUM_TGT-1:0][xbar_pkg::DATA_W-1:0]   tgt_req_wdata_o;
  logic [xbar_pkg::NUM_TGT-1:0][xbar_pkg::STRB_W-1:0]   tgt_req_strb_o;
  logic [xbar_pkg::NUM_TGT-1:0]                         tgt_rsp_valid_i;
  logic [xbar_pkg::NUM_TGT-1:0]                         tgt_rsp_ready_o;
  logic [xbar_pkg::NUM_TGT-1:0][xbar_pkg::DATA_W-1:0]   tgt_rsp_rdata_i;
  xbar_pkg::xbar_resp_e [xbar_pkg::NUM_TGT-1:0]         tgt_rsp_resp_i;

  // Test lines as read from the data file
  int                          n_tests;
  int                          t_init  [MAX_TESTS];
  logic                        t_op    [MAX_TESTS];
  logic [xbar_pkg::ADDR_W-1:0] t_addr  [MAX_TESTS];
  logic [xbar_pkg::DATA_W-1:0] t_wdata [MAX_TESTS];
  logic [xbar_pkg::STRB_W-1:0] t_strb  [MAX_TESTS];
  logic [xbar_pkg::DATA_W-1:0] t_rdata [MAX_TESTS];
  logic [1:0]                  t_resp  [MAX_TESTS];

  xbar_top dut_i (.*);

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
      report_error("Flag mismatch");
    end
  endtask

  task automatic check_data(input string name, input logic [xbar_pkg::DATA_W-1:0] exp,
                            input logic [xbar_pkg::DATA_W-1:0] act);
    if (act !== exp) begin
      $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
      report_error("Data mismatch");
    end
  endtask

  task automatic check_resp(input string name, input xbar_pkg::xbar_resp_e exp,
                            input xbar_pkg::xbar_resp_e act);
    if (act !== exp) begin
      $display("FAIL %0t %s expected %s got %s", $time, name, exp.name(), act.name());
      report_error("Response code mismatch");
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  initial begin
    string line;
    int    fd;
    int    cyc;
    void'($urandom(32'h461c));
    rst_i <= 1'b1;
    n_tests = 0;
    fd = $fopen("testbench/xbar_tests.txt", "r");
    if (fd == 0) report_error("Cannot open testbench/xbar_tests.txt");
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line[0] != "#") begin  // Skip comments and blank lines
        if (n_tests >= MAX_TESTS) report_error("Too many lines in the test file");
        if ($sscanf(line, "%d %h %h %h %h %h %h", t_init[n_tests], t_op[n_tests],
                    t_addr[n_tests], t_wdata[n_tests], t_strb[n_tests],
                    t_rdata[n_tests], t_resp[n_tests]) != 7)
          report_error({"Malformed test line: ", line});
        n_tests++;
      end
    end
    $fclose(fd);
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    for (int p = 0; p < int'(xbar_pkg::NUM_INIT); p++) begin
      check_flag($sformatf("init_req_ready_o[%0d]", p), 1'b0, init_req_ready_o[p]);
      check_flag($sformatf("init_rsp_valid_o[%0d]", p), 1'b0, init_rsp_valid_o[p]);
    end
    for (int j = 0; j < int'(xbar_pkg::NUM_TGT); j++)
      check_flag($sformatf("tgt_req_valid_o[%0d]", j), 1'b0, tgt_req_valid_o[j]);
    go = 1'b1;
    cyc = 0;
    while (init_done != '1) begin
      @(posedge clk_i);
      cyc++;
      if (cyc > 20 * TIMEOUT) report_error("Timeout: initiators never finished their lines");
    end
    $display("** PASS **");
    $finish;
  end

  for (genvar p = 0; p < xbar_pkg::NUM_INIT; p++) begin : gen_initiator
    logic                        req_valid;
    logic [xbar_pkg::ADDR_W-1:0] req_addr;
    xbar_pkg::xbar_op_e          req_op;
    logic [xbar_pkg::DATA_W-1:0] req_wdata;
    logic [xbar_pkg::STRB_W-1:0] req_strb;
    logic                        rsp_ready;
    logic                        finished;

    assign init_req_valid_i[p] = req_valid;
    assign init_req_addr_i[p]  = req_addr;
    assign init_req_op_i[p]    = req_op;
    assign init_req_wdata_i[p] = req_wdata;
    assign init_req_strb_i[p]  = req_strb;
    assign init_rsp_ready_i[p] = rsp_ready;
    assign init_done[p]        = finished;

    initial begin
      logic [xbar_pkg::DATA_W-1:0] rdata;
      xbar_pkg::xbar_resp_e        resp;
      int                          cyc;
      finished = 1'b0;
      req_valid <= 1'b0;
      req_addr  <= '0;
      req_op    <= xbar_pkg::OP_READ;
      req_wdata <= '0;
      req_strb  <= '0;
      rsp_ready <= 1'b0;
      cyc = 0;
      do begin
        @(posedge clk_i);
        cyc++;
        if (cyc > TIMEOUT) report_error($sformatf("Initiator %0d never saw the start", p));
      end while (!go);
      for (int k = 0; k < n_tests; k++) begin
        if (t_init[k] == p) begin
          req_valid <= 1'b1;
          req_addr  <= t_addr[k];
          req_op    <= xbar_pkg::xbar_op_e'(t_op[k]);
          req_wdata <= t_wdata[k];
          req_strb  <= t_strb[k];
          cyc = 0;
          forever begin
            @(negedge clk_i);
            if (init_req_ready_o[p]) break;
            cyc++;
            if (cyc > TIMEOUT) report_error($sformatf("Timeout: initiator %0d request hung", p));
            @(posedge clk_i);
          end
          @(posedge clk_i);   // Request transfer
          req_valid <= 1'b0;
          cyc = 0;
          forever begin
            rsp_ready <= ($urandom % 3) != 0;
            @(negedge clk_i);
            if (init_rsp_valid_o[p] && rsp_ready) break;
            cyc++;
            if (cyc > TIMEOUT) report_error($sformatf("Timeout: initiator %0d response hung", p));
            @(posedge clk_i);
          end
          rdata = init_rsp_rdata_o[p];
          resp  = init_rsp_resp_o[p];
          @(posedge clk_i);
          rsp_ready <= 1'b0;
          check_data($sformatf("init_rsp_rdata_o[%0d]", p), t_rdata[k], rdata);
          check_resp($sformatf("init_rsp_resp_o[%0d]", p), xbar_pkg::xbar_resp_e'(t_resp[k]),
                     resp);
        end
      end
      finished = 1'b1;
    end
  end

  for (genvar j = 0; j < xbar_pkg::NUM_TGT; j++) begin : gen_target
    logic                        req_ready;
    logic                        rsp_valid;
    logic [xbar_pkg::DATA_W-1:0] rsp_rdata;
    logic [xbar_pkg::DATA_W-1:0] mem [256];

    assign tgt_req_ready_i[j] = req_ready;
    assign tgt_rsp_valid_i[j] = rsp_valid;
    assign tgt_rsp_rdata_i[j] = rsp_rdata;
    assign tgt_rsp_resp_i[j]  = xbar_pkg::RESP_OKAY;

    initial begin
      logic [xbar_pkg::ADDR_W-1:0] addr;
      logic [xbar_pkg::ADDR_W-1:0] lo;
      logic [xbar_pkg::ADDR_W-1:0] hi;
      xbar_pkg::xbar_op_e          op;
      logic [xbar_pkg::DATA_W-1:0] wdata;
      logic [xbar_pkg::STRB_W-1:0] strb;
      int                          delay;
      int                          cyc;
      req_ready <= 1'b0;
      rsp_valid <= 1'b0;
      rsp_rdata <= '0;
      lo = (j == 0) ? xbar_pkg::TGT0_BASE : xbar_pkg::TGT1_BASE;
      hi = (j == 0) ? xbar_pkg::TGT0_END : xbar_pkg::TGT1_END;
      for (int w = 0; w < 256; w++) mem[w] = '0;
      cyc = 0;
      do begin
        @(posedge clk_i);
        cyc++;
        if (cyc > TIMEOUT) report_error($sformatf("Target %0d never saw the start", j));
      end while (!go);
      forever begin
        req_ready <= ($urandom % 4) != 0;  // Random stall
        @(negedge clk_i);
        if (tgt_req_valid_o[j] && req_ready) begin
          addr  = tgt_req_addr_o[j];
          op    = tgt_req_op_o[j];
          wdata = tgt_req_wdata_o[j];
          strb  = tgt_req_strb_o[j];
          if (addr < lo || addr > hi)
            report_error($sformatf("Target %0d got address %h outside its range", j, addr));
          @(posedge clk_i);
          req_ready <= 1'b0;
          delay = int'($urandom % 4);
          for (int d = 0; d < delay; d++) begin
            @(negedge clk_i);
            if (tgt_req_valid_o[j])
              report_error($sformatf("Target %0d saw a second request while busy", j));
            @(posedge clk_i);
          end
          if (op == xbar_pkg::OP_WRITE) begin
            for (int b = 0; b < int'(xbar_pkg::STRB_W); b++)
              if (strb[b]) mem[addr[9:2]][b*8 +: 8] = wdata[b*8 +: 8];
            rsp_rdata <= '0;
          end else begin
            rsp_rdata <= mem[addr[9:2]];
          end
          rsp_valid <= 1'b1;
          cyc = 0;
          forever begin
            @(negedge clk_i);
            if (tgt_req_valid_o[j])
              report_error($sformatf("Target %0d saw a second request while busy", j));
            if (tgt_rsp_ready_o[j]) break;
            cyc++;
            if (cyc > TIMEOUT) report_error($sformatf("Timeout: target %0d response hung", j));
            @(posedge clk_i);
          end
          @(posedge clk_i);   // Response transfer
          rsp_valid <= 1'b0;
        end else begin
          @(posedge clk_i);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/xbar_top.sv ====
`default_nettype none

module xbar_top (
  input  logic                                                 clk_i,
  input  logic                                                 rst_i,
  // Initiator ports
  input  logic [xbar_pkg::NUM_INIT-1:0]                        init_req_valid_i,
  output logic [xbar_pkg::NUM_INIT-1:0]                        init_req_ready_o,
  input  logic [xbar_pkg::NUM_INIT-1:0][xbar_pkg::ADDR_W-1:0]  init_req_addr_i,
  input  xbar_pkg::xbar_op_e [xbar_pkg::NUM_INIT-1:0]          init_req_op_i,
  input  logic [xbar_pkg::NUM_INIT-1:0][xbar_pkg::DATA_W-1:0]  init_req_wdata_i,
  input  logic [xbar_pkg::NUM_INIT-1:0][xbar_pkg::STRB_W-1:0]  init_req_strb_i,
  output logic [xbar_pkg::NUM_INIT-1:0]                        init_rsp_valid_o,
  input  logic [xbar_pkg::NUM_INIT-1:0]                        init_rsp_ready_i,
  output logic [xbar_pkg::NUM_INIT-1:0][xbar_pkg::DATA_W-1:0]  init_rsp_rdata_o,
  output xbar_pkg::xbar_resp_e [xbar_pkg::NUM_INIT-1:0]        init_rsp_resp_o,
  // Target ports
  output logic [xbar_pkg::NUM_TGT-1:0]                         tgt_req_valid_o,
  input  logic [xbar_pkg::NUM_TGT-1:0]                         tgt_req_ready_i,
  output logic [xbar_pkg::NUM_TGT-1:0][xbar_pkg::ADDR_W-1:0]   tgt_req_addr_o,
  output xbar_pkg::xbar_op_e [xbar_pkg::NUM_TGT-1:0]           tgt_req_op_o,
  output logic [xbar_pkg::NUM_TGT-1:0][xbar_pkg::DATA_W-1:0]   tgt_req_wdata_o,
  output logic [xbar_pkg::NUM_TGT-1:0][xbar_pkg::STRB_W-1:0]   tgt_req_strb_o,
  input  logic [xbar_pkg::NUM_TGT-1:0]                         tgt_rsp_valid_i,
  output logic [xbar_pkg::NUM_TGT-1:0]                         tgt_rsp_ready_o,
  input  logic [xbar_pkg::NUM_TGT-1:0][xbar_pkg::DATA_W-1:0]   tgt_rsp_rdata_i,
  input  xbar_pkg::xbar_resp_e [xbar_pkg::NUM_TGT-1:0]         tgt_rsp_resp_i
);

  // Demux side, indexed [initiator][output]
  logic [xbar_pkg::NUM_INIT-1:0][xbar_pkg::NUM_TGT:0]                        dmx_req_valid;
  logic [xbar_pkg::NUM_INIT-1:0][xbar_pkg::NUM_TGT:0]                        dmx_req_ready;
  logic [xbar_pkg::NUM_INIT-1:0][xbar_pkg::NUM_TGT:0][xbar_pkg::ADDR_W-1:0]  dmx_req_addr;
  xbar_pkg::xbar_op_e [xbar_pkg::NUM_INIT-1:0][xbar_pkg::NUM_TGT:0]          dmx_req_op;
  logic [xbar_pkg::NUM_INIT-1:0][xbar_pkg::NUM_TGT:0][xbar_pkg::DATA_W-1:0]  dmx_req_wdata;
  logic [xbar_pkg::NUM_INIT-1:0][xbar_pkg::NUM_TGT:0][xbar_pkg::STRB_W-1:0]  dmx_req_strb;
  logic [xbar_pkg::NUM_INIT-1:0][xbar_pkg::NUM_TGT:0]                        dmx_rsp_valid;
  logic [xbar_pkg::NUM_INIT-1:0][xbar_pkg::NUM_TGT:0]                        dmx_rsp_ready;
  logic [xbar_pkg::NUM_INIT-1:0][xbar_pkg::NUM_TGT:0][xbar_pkg::DATA_W-1:0]  dmx_rsp_rdata;
  xbar_pkg::xbar_resp_e [xbar_pkg::NUM_INIT-1:0][xbar_pkg::NUM_TGT:0]        dmx_rsp_resp;

  // Mux side, indexed [target][initiator]
  logic [xbar_pkg::NUM_TGT-1:0][xbar_pkg::NUM_INIT-1:0]                      mux_req_valid;
  logic [xbar_pkg::NUM_TGT-1:0][xbar_pkg::NUM_INIT-1:0]                      mux_req_ready;
  logic [xbar_pkg::NUM_TGT-1:0][xbar_pkg::NUM_INIT-1:0][xbar_pkg::ADDR_W-1:0] mux_req_addr;
  xbar_pkg::xbar_op_e [xbar_pkg::NUM_TGT-1:0][xbar_pkg::NUM_INIT-1:0]        mux_req_op;
  logic [xbar_pkg::NUM_TGT-1:0][xbar_pkg::NUM_INIT-1:0][xbar_pkg::DATA_W-1:0] mux_req_wdata;
  logic [xbar_pkg::NUM_TGT-1:0][xbar_pkg::NUM_INIT-1:0][xbar_pkg::STRB_W-1:0] mux_req_strb;
  logic [xbar_pkg::NUM_TGT-1:0][xbar_pkg::NUM_INIT-1:0]                      mux_rsp_valid;
  logic [xbar_pkg::NUM_TGT-1:0][xbar_pkg::NUM_INIT-1:0]                      mux_rsp_ready;
  logic [xbar_pkg::NUM_TGT-1:0][xbar_pkg::NUM_INIT-1:0][xbar_pkg::DATA_W-1:0] mux_rsp_rdata;
  xbar_pkg::xbar_resp_e [xbar_pkg::NUM_TGT-1:0][xbar_pkg::NUM_INIT-1:0]      mux_rsp_resp;

  for (genvar i = 0; i < xbar_pkg::NUM_INIT; i++) begin : gen_init
    xbar_demux i_demux (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .req_valid_i     (init_req_valid_i[i]),
      .req_ready_o     (init_req_ready_o[i]),
      .req_addr_i      (init_req_addr_i[i]),
      .req_op_i        (init_req_op_i[i]),
      .req_wdata_i     (init_req_wdata_i[i]),
      .req_strb_i      (init_req_strb_i[i]),
      .rsp_valid_o     (init_rsp_valid_o[i]),
      .rsp_ready_i     (init_rsp_ready_i[i]),
      .rsp_rdata_o     (init_rsp_rdata_o[i]),
      .rsp_resp_o      (init_rsp_resp_o[i]),
      .mst_req_valid_o (dmx_req_valid[i]),
      .mst_req_ready_i (dmx_req_ready[i]),
      .mst_req_addr_o  (dmx_req_addr[i]),
      .mst_req_op_o    (dmx_req_op[i]),
      .mst_req_wdata_o (dmx_req_wdata[i]),
      .mst_req_strb_o  (dmx_req_strb[i]),
      .mst_rsp_valid_i (dmx_rsp_valid[i]),
      .mst_rsp_ready_o (dmx_rsp_ready[i]),
      .mst_rsp_rdata_i (dmx_rsp_rdata[i]),
      .mst_rsp_resp_i  (dmx_rsp_resp[i])
    );

    // Last demux output ends here
    xbar_err_target i_err_target (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_valid_i (dmx_req_valid[i][xbar_pkg::NUM_TGT]),
      .req_ready_o (dmx_req_ready[i][xbar_pkg::NUM_TGT]),
      .req_op_i    (dmx_req_op[i][xbar_pkg::NUM_TGT]),
      .rsp_valid_o (dmx_rsp_valid[i][xbar_pkg::NUM_TGT]),
      .rsp_ready_i (dmx_rsp_ready[i][xbar_pkg::NUM_TGT]),
      .rsp_rdata_o (dmx_rsp_rdata[i][xbar_pkg::NUM_TGT]),
      .rsp_resp_o  (dmx_rsp_resp[i][xbar_pkg::NUM_TGT])
    );

    for (genvar j = 0; j < xbar_pkg::NUM_TGT; j++) begin : gen_cross
      assign mux_req_valid[j][i] = dmx_req_valid[i][j];
      assign mux_req_addr[j][i]  = dmx_req_addr[i][j];
      assign mux_req_op[j][i]    = dmx_req_op[i][j];
      assign mux_req_wdata[j][i] = dmx_req_wdata[i][j];
      assign mux_req_strb[j][i]  = dmx_req_strb[i][j];
      assign mux_rsp_ready[j][i] = dmx_rsp_ready[i][j];
      assign dmx_req_ready[i][j] = mux_req_ready[j][i];
      assign dmx_rsp_valid[i][j] = mux_rsp_valid[j][i];
      assign dmx_rsp_rdata[i][j] = mux_rsp_rdata[j][i];
      assign dmx_rsp_resp[i][j]  = mux_rsp_resp[j][i];
    end
  end

  for (genvar j = 0; j < xbar_pkg::NUM_TGT; j++) begin : gen_tgt
    xbar_mux i_mux (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .slv_req_valid_i (mux_req_valid[j]),
      .slv_req_ready_o (mux_req_ready[j]),
      .slv_req_addr_i  (mux_req_addr[j]),
      .slv_req_op_i    (mux_req_op[j]),
      .slv_req_wdata_i (mux_req_wdata[j]),
      .slv_req_strb_i  (mux_req_strb[j]),
      .slv_rsp_valid_o (mux_rsp_valid[j]),
      .slv_rsp_ready_i (mux_rsp_ready[j]),
      .slv_rsp_rdata_o (mux_rsp_rdata[j]),
      .slv_rsp_resp_o  (mux_rsp_resp[j]),
      .req_valid_o     (tgt_req_valid_o[j]),
      .req_ready_i     (tgt_req_ready_i[j]),
      .req_addr_o      (tgt_req_addr_o[j]),
      .req_op_o        (tgt_req_op_o[j]),
      .req_wdata_o     (tgt_req_wdata_o[j]),
      .req_strb_o      (tgt_req_strb_o[j]),
      .rsp_valid_i     (tgt_rsp_valid_i[j]),
      .rsp_ready_o     (tgt_rsp_ready_o[j]),
      .rsp_rdata_i     (tgt_rsp_rdata_i[j]),
      .rsp_resp_i      (tgt_rsp_resp_i[j])
    );
  end

endmodule

`default_nettype wire

// ==== src/xbar_mux.sv ====
`default_nettype none

module xbar_mux (
  input  logic                                                 clk_i,
  input  logic                                                 rst_i,
  // Initiator side, one entry per demux
  input  logic [xbar_pkg::NUM_INIT-1:0]                        slv_req_valid_i,
  output logic [xbar_pkg::NUM_INIT-1:0]                        slv_req_ready_o,
  input  logic [xbar_pkg::NUM_INIT-1:0][xbar_pkg::ADDR_W-1:0]  slv_req_addr_i,
  input  xbar_pkg::xbar_op_e [xbar_pkg::NUM_INIT-1:0]          slv_req_op_i,
  input  logic [xbar_pkg::NUM_INIT-1:0][xbar_pkg::DATA_W-1:0]  slv_req_wdata_i,
  input  logic [xbar_pkg::NUM_INIT-1:0][xbar_pkg::STRB_W-1:0]  slv_req_strb_i,
  output logic [xbar_pkg::NUM_INIT-1:0]                        slv_rsp_valid_o,
  input  logic [xbar_pkg::NUM_INIT-1:0]                        slv_rsp_ready_i,
  output logic [xbar_pkg::NUM_INIT-1:0][xbar_pkg::DATA_W-1:0]  slv_rsp_rdata_o,
  output xbar_pkg::xbar_resp_e [xbar_pkg::NUM_INIT-1:0]        slv_rsp_resp_o,
  // Target side
  output logic                                                 req_valid_o,
  input  logic                                                 req_ready_i,
  output logic [xbar_pkg::ADDR_W-1:0]                          req_addr_o,
  output xbar_pkg::xbar_op_e                                   req_op_o,
  output logic [xbar_pkg::DATA_W-1:0]                          req_wdata_o,
  output logic [xbar_pkg::STRB_W-1:0]                          req_strb_o,
  input  logic                                                 rsp_valid_i,
  output logic                                                 rsp_ready_o,
  input  logic [xbar_pkg::DATA_W-1:0]                          rsp_rdata_i,
  input  xbar_pkg::xbar_resp_e                                 rsp_resp_i
);

  xbar_pkg::mux_state_e          state_q;
  logic [xbar_pkg::INIT_W-1:0]   rr_ptr_q;  // Highest priority initiator
  logic [xbar_pkg::INIT_W-1:0]   gnt_q;
  logic [xbar_pkg::INIT_W-1:0]   gnt_d;
  logic                          gnt_vld;
  logic [xbar_pkg::INIT_W-1:0]   sel;

  // Round robin search starting at the pointer
  always_comb begin
    logic [xbar_pkg::INIT_W-1:0] cand;
    gnt_d   = rr_ptr_q;
    gnt_vld = 1'b0;
    for (int k = 0; k < int'(xbar_pkg::NUM_INIT); k++) begin
      cand = xbar_pkg::INIT_W'((32'(rr_ptr_q) + 32'(k)) % xbar_pkg::NUM_INIT);
      if (!gnt_vld && slv_req_valid_i[cand]) begin
        gnt_d   = cand;
        gnt_vld = 1'b1;
      end
    end
  end

  // Fresh grant passes straight through while idle
  assign sel = (state_q == xbar_pkg::MUX_IDLE) ? gnt_d : gnt_q;

  always_comb begin
    case (state_q)
      xbar_pkg::MUX_IDLE: req_valid_o = gnt_vld;
      xbar_pkg::MUX_REQ:  req_valid_o = slv_req_valid_i[gnt_q];
      default:            req_valid_o = 1'b0;
    endcase
  end

  assign req_addr_o  = slv_req_addr_i[sel];
  assign req_op_o    = slv_req_op_i[sel];
  assign req_wdata_o = slv_req_wdata_i[sel];
  assign req_strb_o  = slv_req_strb_i[sel];

  assign rsp_ready_o = (state_q == xbar_pkg::MUX_RSP) && slv_rsp_ready_i[gnt_q];

  always_comb begin
    for (int k = 0; k < int'(xbar_pkg::NUM_INIT); k++) begin
      slv_req_ready_o[k] = req_valid_o && req_ready_i && (sel == xbar_pkg::INIT_W'(k));
      slv_rsp_valid_o[k] = (state_q == xbar_pkg::MUX_RSP) && rsp_valid_i &&
                           (gnt_q == xbar_pkg::INIT_W'(k));
      slv_rsp_rdata_o[k] = rsp_rdata_i;
      slv_rsp_resp_o[k]  = rsp_resp_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= xbar_pkg::MUX_IDLE;
      rr_ptr_q <= '0;
      gnt_q    <= '0;
    end else begin
      case (state_q)
        xbar_pkg::MUX_IDLE: begin
          if (gnt_vld) begin
            gnt_q    <= gnt_d;
            rr_ptr_q <= xbar_pkg::INIT_W'((32'(gnt_d) + 32'd1) % xbar_pkg::NUM_INIT);
            // Target may accept in the grant cycle already
            state_q  <= req_ready_i ? xbar_pkg::MUX_RSP : xbar_pkg::MUX_REQ;
          end
        end
        xbar_pkg::MUX_REQ: begin
          if (req_valid_o && req_ready_i) state_q <= xbar_pkg::MUX_RSP;
        end
        xbar_pkg::MUX_RSP: begin
          if (rsp_valid_i && rsp_ready_o) state_q <= xbar_pkg::MUX_IDLE;
        end
        default: state_q <= xbar_pkg::MUX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/xbar_err_target.sv ====
`default_nettype none

module xbar_err_target (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  input  xbar_pkg::xbar_op_e          req_op_i,
  output logic                        rsp_valid_o,
  input  logic                        rsp_ready_i,
  output logic [xbar_pkg::DATA_W-1:0] rsp_rdata_o,
  output xbar_pkg::xbar_resp_e        rsp_resp_o
);

  xbar_pkg::err_state_e state_q;

  // Reads and writes alike are taken, one at a time
  assign req_ready_o = (state_q == xbar_pkg::ERR_IDLE) && req_valid_i;

  assign rsp_valid_o = (state_q == xbar_pkg::ERR_RSP);
  assign rsp_rdata_o = '0;                   // No data behind an unmapped address
  assign rsp_resp_o  = xbar_pkg::RESP_DECERR;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= xbar_pkg::ERR_IDLE;
    end else begin
      case (state_q)
        xbar_pkg::ERR_IDLE: if (req_valid_i && req_ready_o) state_q <= xbar_pkg::ERR_RSP;
        xbar_pkg::ERR_RSP:  if (rsp_ready_i) state_q <= xbar_pkg::ERR_IDLE;
        default:            state_q <= xbar_pkg::ERR_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/xbar_demux.sv ====
`default_nettype none

module xbar_demux (
  input  logic                                                 clk_i,
  input  logic                                                 rst_i,
  // Initiator side
  input  logic                                                 req_valid_i,
  output logic                                                 req_ready_o,
  input  logic [xbar_pkg::ADDR_W-1:0]                          req_addr_i,
  input  xbar_pkg::xbar_op_e                                   req_op_i,
  input  logic [xbar_pkg::DATA_W-1:0]                          req_wdata_i,
  input  logic [xbar_pkg::STRB_W-1:0]                          req_strb_i,
  output logic                                                 rsp_valid_o,
  input  logic                                                 rsp_ready_i,
  output logic [xbar_pkg::DATA_W-1:0]                          rsp_rdata_o,
  output xbar_pkg::xbar_resp_e                                 rsp_resp_o,
  // Target side, last index is the error responder
  output logic [xbar_pkg::NUM_TGT:0]                           mst_req_valid_o,
  input  logic [xbar_pkg::NUM_TGT:0]                           mst_req_ready_i,
  output logic [xbar_pkg::NUM_TGT:0][xbar_pkg::ADDR_W-1:0]     mst_req_addr_o,
  output xbar_pkg::xbar_op_e [xbar_pkg::NUM_TGT:0]             mst_req_op_o,
  output logic [xbar_pkg::NUM_TGT:0][xbar_pkg::DATA_W-1:0]     mst_req_wdata_o,
  output logic [xbar_pkg::NUM_TGT:0][xbar_pkg::STRB_W-1:0]     mst_req_strb_o,
  input  logic [xbar_pkg::NUM_TGT:0]                           mst_rsp_valid_i,
  output logic [xbar_pkg::NUM_TGT:0]                           mst_rsp_ready_o,
  input  logic [xbar_pkg::NUM_TGT:0][xbar_pkg::DATA_W-1:0]     mst_rsp_rdata_i,
  input  xbar_pkg::xbar_resp_e [xbar_pkg::NUM_TGT:0]           mst_rsp_resp_i
);

  xbar_pkg::demux_state_e        state_q;
  logic [xbar_pkg::IDX_W-1:0]    dec_idx;   // Error index NUM_TGT when unmapped
  logic [xbar_pkg::IDX_W-1:0]    sel_q;     // Output owning the open transaction

  xbar_addr_decode i_addr_decode (
    .addr_i      (req_addr_i),
    .idx_o       (dec_idx),
    .dec_error_o ()
  );

  // Payload goes everywhere, only valid is steered
  always_comb begin
    for (int k = 0; k <= int'(xbar_pkg::NUM_TGT); k++) begin
      mst_req_valid_o[k] = (state_q == xbar_pkg::DMX_IDLE) && req_valid_i &&
                           (dec_idx == xbar_pkg::IDX_W'(k));
      mst_rsp_ready_o[k] = (state_q == xbar_pkg::DMX_WAIT) && rsp_ready_i &&
                           (sel_q == xbar_pkg::IDX_W'(k));
      mst_req_addr_o[k]  = req_addr_i;
      mst_req_op_o[k]    = req_op_i;
      mst_req_wdata_o[k] = req_wdata_i;
      mst_req_strb_o[k]  = req_strb_i;
    end
  end

  assign req_ready_o = (state_q == xbar_pkg::DMX_IDLE) && req_valid_i &&
                       mst_req_ready_i[dec_idx];

  // Response comes back only from the latched output
  assign rsp_valid_o = (state_q == xbar_pkg::DMX_WAIT) && mst_rsp_valid_i[sel_q];
  assign rsp_rdata_o = mst_rsp_rdata_i[sel_q];
  assign rsp_resp_o  = mst_rsp_resp_i[sel_q];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= xbar_pkg::DMX_IDLE;
      sel_q   <= '0;
    end else begin
      case (state_q)
        xbar_pkg::DMX_IDLE: begin
          if (req_valid_i && req_ready_o) begin
            state_q <= xbar_pkg::DMX_WAIT;
            sel_q   <= dec_idx;
          end
        end
        xbar_pkg::DMX_WAIT: begin
          if (rsp_valid_o && rsp_ready_i) state_q <= xbar_pkg::DMX_IDLE;
        end
        default: state_q <= xbar_pkg::DMX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/xbar_addr_decode.sv ====
`default_nettype none

module xbar_addr_decode (
  input  logic [xbar_pkg::ADDR_W-1:0] addr_i,
  output logic [xbar_pkg::IDX_W-1:0]  idx_o,
  output logic                        dec_error_o
);

  logic hit_tgt0;
  logic hit_tgt1;

  // Offset from base wraps below it, so one compare covers both bounds
  assign hit_tgt0 = (addr_i - xbar_pkg::TGT0_BASE) <=
                    (xbar_pkg::TGT0_END - xbar_pkg::TGT0_BASE);
  assign hit_tgt1 = (addr_i - xbar_pkg::TGT1_BASE) <=
                    (xbar_pkg::TGT1_END - xbar_pkg::TGT1_BASE);

  always_comb begin
    // Unmapped goes to the error index
    idx_o       = xbar_pkg::IDX_W'(xbar_pkg::NUM_TGT);
    dec_error_o = 1'b1;
    if (hit_tgt0) begin
      idx_o       = xbar_pkg::IDX_W'(0);
      dec_error_o = 1'b0;
    end else if (hit_tgt1) begin
      idx_o       = xbar_pkg::IDX_W'(1);
      dec_error_o = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== src/xbar_pkg.sv ====
`default_nettype none

package xbar_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  // Port counts
  localparam int unsigned NUM_INIT = 2;
  localparam int unsigned NUM_TGT  = 2;
  localparam int unsigned INIT_W   = $clog2(NUM_INIT);
  localparam int unsigned IDX_W    = $clog2(NUM_TGT + 1); // Extra code for decode error

  // Address map, inclusive ranges
  localparam logic [ADDR_W-1:0] TGT0_BASE = 16'h0000;
  localparam logic [ADDR_W-1:0] TGT0_END  = 16'h0FFF;
  localparam logic [ADDR_W-1:0] TGT1_BASE = 16'h1000;
  localparam logic [ADDR_W-1:0] TGT1_END  = 16'h1FFF;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } xbar_op_e;

  // Same codes as AXI BRESP/RRESP
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_DECERR = 2'b11
  } xbar_resp_e;

  typedef enum logic {
    DMX_IDLE,
    DMX_WAIT
  } demux_state_e;

  typedef enum logic [1:0] {
    MUX_IDLE,
    MUX_REQ,
    MUX_RSP
  } mux_state_e;

  typedef enum logic {
    ERR_IDLE,
    ERR_RSP
  } err_state_e;

endpackage

`default_nettype wire
